// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Iinclude
TOP       ?= tb_eth_rx_top
FILELIST  ?= compile.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
hw/eth_rx_pkg.sv
hw/crc32.sv
hw/frame_rx.sv
hw/mac_rx.sv
hw/ip_rx.sv
hw/udp_rx.sv
hw/payload_fifo.sv
hw/eth_rx_top.sv
testbench/tb_eth_rx_top.sv

// ==== hw/crc32.sv ====
`timescale 1ns/1ps

module crc32 (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       init,
    input  logic       enable,
    input  logic [7:0] data,
    output logic       residue_ok
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;
    logic [31:0] crc_rev;

    // lsb-first byte update with the reflected polynomial.
    always_comb begin
        crc_next = crc_q ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            crc_next = crc_next[0] ? ((crc_next >> 1) ^ 32'hEDB88320) : (crc_next >> 1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crc_q <= '1;
        end else if (init) begin
            crc_q <= '1;
        end else if (enable) begin
            crc_q <= crc_next;
        end
    end

    // register is reflected, the residue constant is not.
    assign crc_rev    = {<<{crc_q}};
    assign residue_ok = (crc_rev == eth_rx_pkg::CRC_RESIDUE);

endmodule

// ==== hw/eth_rx_pkg.sv ====
package eth_rx_pkg;

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        DATA,
        DROP
    } frame_state_t;

    // shared by the mac, ip and udp parsers.
    typedef enum logic [1:0] {
        HEADER,
        PAYLOAD,
        SKIP
    } hdr_state_t;

    localparam int MAC_W  = 48;
    localparam int IP_W   = 32;
    localparam int PORT_W = 16;
    localparam int LEN_W  = 16;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    // crc register after the fcs bytes, msb-first form.
    localparam logic [31:0] CRC_RESIDUE = 32'hC704DD7B;

    // destination mac through fcs.
    localparam logic [LEN_W-1:0] MIN_FRAME_BYTES = 16'd64;

endpackage

// ==== hw/eth_rx_top.sv ====
`timescale 1ns/1ps

module eth_rx_top #(
    parameter logic [eth_rx_pkg::MAC_W-1:0] LOCAL_MAC  = 48'h02_00_00_00_00_01,
    parameter logic [eth_rx_pkg::IP_W-1:0]  LOCAL_IP   = 32'h0A_00_00_02,
    parameter int                           FIFO_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [7:0]                    rxd,
    input  logic                          rxdv,
    input  logic                          out_ready,
    output logic [7:0]                    out_data,
    output logic                          out_valid,
    output logic                          out_last,
    output logic                          hdr_valid,
    output logic [eth_rx_pkg::MAC_W-1:0]  src_mac,
    output logic [eth_rx_pkg::MAC_W-1:0]  dst_mac,
    output logic [eth_rx_pkg::IP_W-1:0]   src_ip,
    output logic [eth_rx_pkg::IP_W-1:0]   dst_ip,
    output logic [eth_rx_pkg::PORT_W-1:0] src_port,
    output logic [eth_rx_pkg::PORT_W-1:0] dst_port,
    output logic [eth_rx_pkg::LEN_W-1:0]  payload_len
);

    logic [7:0] mac_data;
    logic [7:0] ip_data;
    logic [7:0] udp_data;
    logic [7:0] wr_data;
    logic       mac_valid, mac_end, mac_ok;
    logic       ip_valid, ip_end, ip_ok;
    logic       udp_valid, udp_end, udp_ok;
    logic       wr_en, wr_last, commit, discard, overflow;

    frame_rx u_frame_rx (
        .clk(clk), .arst_n(arst_n), .rxd(rxd), .rxdv(rxdv),
        .mac_data(mac_data), .mac_valid(mac_valid), .mac_end(mac_end), .mac_ok(mac_ok)
    );

    mac_rx #(.LOCAL_MAC(LOCAL_MAC)) u_mac_rx (
        .clk(clk), .arst_n(arst_n),
        .in_data(mac_data), .in_valid(mac_valid), .in_end(mac_end), .in_ok(mac_ok),
        .ip_data(ip_data), .ip_valid(ip_valid), .ip_end(ip_end), .ip_ok(ip_ok),
        .src_mac(src_mac), .dst_mac(dst_mac)
    );

    ip_rx #(.LOCAL_IP(LOCAL_IP)) u_ip_rx (
        .clk(clk), .arst_n(arst_n),
        .in_data(ip_data), .in_valid(ip_valid), .in_end(ip_end), .in_ok(ip_ok),
        .udp_data(udp_data), .udp_valid(udp_valid), .udp_end(udp_end), .udp_ok(udp_ok),
        .src_ip(src_ip), .dst_ip(dst_ip)
    );

    udp_rx u_udp_rx (
        .clk(clk), .arst_n(arst_n),
        .in_data(udp_data), .in_valid(udp_valid), .in_end(udp_end), .in_ok(udp_ok),
        .overflow(overflow),
        .wr_data(wr_data), .wr_en(wr_en), .wr_last(wr_last),
        .commit(commit), .discard(discard),
        .src_port(src_port), .dst_port(dst_port), .payload_len(payload_len),
        .hdr_valid(hdr_valid)
    );

    payload_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_payload_fifo (
        .clk(clk), .arst_n(arst_n),
        .wr_data(wr_data), .wr_en(wr_en), .wr_last(wr_last),
        .commit(commit), .discard(discard), .out_ready(out_ready), .overflow(overflow),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last)
    );

endmodule

// ==== hw/frame_rx.sv ====
`timescale 1ns/1ps

module frame_rx (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] rxd,
    input  logic       rxdv,
    output logic [7:0] mac_data,
    output logic       mac_valid,
    output logic       mac_end,
    output logic       mac_ok
);

    eth_rx_pkg::frame_state_t state;

    logic [eth_rx_pkg::LEN_W-1:0] byte_cnt;
    logic                         sfd_hit;
    logic                         crc_en;
    logic                         residue_ok;

    assign sfd_hit = (state == eth_rx_pkg::PREAMBLE) && rxdv && (rxd == 8'hD5);
    assign crc_en  = (state == eth_rx_pkg::DATA) && rxdv;

    crc32 u_crc32 (
        .clk(clk), .arst_n(arst_n), .init(sfd_hit), .enable(crc_en), .data(rxd),
        .residue_ok(residue_ok)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= eth_rx_pkg::IDLE;
            byte_cnt  <= '0;
            mac_valid <= 1'b0;
            mac_end   <= 1'b0;
            mac_ok    <= 1'b0;
        end else begin
            mac_valid <= 1'b0;
            mac_end   <= 1'b0;
            case (state)
                eth_rx_pkg::IDLE: begin
                    if (rxdv) begin
                        state <= (rxd == 8'h55) ? eth_rx_pkg::PREAMBLE : eth_rx_pkg::DROP;
                    end
                end
                eth_rx_pkg::PREAMBLE: begin
                    if (!rxdv) begin
                        state <= eth_rx_pkg::IDLE;
                    end else if (sfd_hit) begin
                        state    <= eth_rx_pkg::DATA;
                        byte_cnt <= '0;
                    end else if (rxd != 8'h55) begin
                        state <= eth_rx_pkg::DROP;
                    end
                end
                eth_rx_pkg::DATA: begin
                    if (rxdv) begin
                        mac_valid <= 1'b1;
                        // saturate so giant frames are not mistaken for runts.
                        if (byte_cnt != '1) begin
                            byte_cnt <= byte_cnt + 16'd1;
                        end
                    end else begin
                        mac_end <= 1'b1;
                        mac_ok  <= residue_ok && (byte_cnt >= eth_rx_pkg::MIN_FRAME_BYTES);
                        state   <= eth_rx_pkg::IDLE;
                    end
                end
                default: begin
                    if (!rxdv) begin
                        state <= eth_rx_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (crc_en) begin
            mac_data <= rxd;
        end
    end

endmodule

// ==== hw/ip_rx.sv ====
`timescale 1ns/1ps

module ip_rx #(
    parameter logic [eth_rx_pkg::IP_W-1:0] LOCAL_IP = 32'h0A_00_00_02
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [7:0]                  in_data,
    input  logic                        in_valid,
    input  logic                        in_end,
    input  logic                        in_ok,
    output logic [7:0]                  udp_data,
    output logic                        udp_valid,
    output logic                        udp_end,
    output logic                        udp_ok,
    output logic [eth_rx_pkg::IP_W-1:0] src_ip,
    output logic [eth_rx_pkg::IP_W-1:0] dst_ip
);

    eth_rx_pkg::hdr_state_t state;

    logic [4:0]                  hdr_cnt;
    logic [15:0]                 total_len;
    logic [15:0]                 left;
    logic [eth_rx_pkg::IP_W-1:0] src_q;
    logic [eth_rx_pkg::IP_W-1:0] dst_q;
    logic                        hdr_bad;
    logic                        field_bad;
    logic                        frame_pass;

    // per-byte header checks. dst_q still lacks its last byte at offset 19.
    always_comb begin
        field_bad = 1'b0;
        case (hdr_cnt)
            5'd0:    field_bad = (in_data != 8'h45);
            5'd6:    field_bad = (in_data[5:0] != 6'd0);
            5'd7:    field_bad = (in_data != 8'd0);
            5'd9:    field_bad = (in_data != eth_rx_pkg::IP_PROTO_UDP);
            5'd19:   field_bad = ({dst_q[23:0], in_data} != LOCAL_IP) || (total_len < 16'd20);
            default: field_bad = 1'b0;
        endcase
    end

    // a datagram cut short by the frame leaves bytes outstanding.
    assign frame_pass = in_ok && (state == eth_rx_pkg::PAYLOAD) && (left == 16'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= eth_rx_pkg::HEADER;
            hdr_cnt   <= '0;
            hdr_bad   <= 1'b0;
            left      <= '0;
            udp_valid <= 1'b0;
            udp_end   <= 1'b0;
            udp_ok    <= 1'b0;
        end else begin
            udp_valid <= 1'b0;
            udp_end   <= in_end;
            if (in_end) begin
                udp_ok  <= frame_pass;
                state   <= eth_rx_pkg::HEADER;
                hdr_cnt <= '0;
                hdr_bad <= 1'b0;
            end else if (in_valid) begin
                case (state)
                    eth_rx_pkg::HEADER: begin
                        hdr_cnt <= hdr_cnt + 5'd1;
                        hdr_bad <= hdr_bad | field_bad;
                        if (hdr_cnt == 5'd19) begin
                            state <= (hdr_bad || field_bad) ? eth_rx_pkg::SKIP
                                                            : eth_rx_pkg::PAYLOAD;
                            left  <= total_len - 16'd20;
                        end
                    end
                    eth_rx_pkg::PAYLOAD: begin
                        // anything past total length is padding or fcs.
                        if (left != 16'd0) begin
                            udp_valid <= 1'b1;
                            left      <= left - 16'd1;
                        end
                    end
                    default: state <= eth_rx_pkg::SKIP;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        udp_data <= in_data;
        if (in_valid && (state == eth_rx_pkg::HEADER)) begin
            case (hdr_cnt) inside
                [5'd2:5'd3]:   total_len <= {total_len[7:0], in_data};
                [5'd12:5'd15]: src_q <= {src_q[23:0], in_data};
                [5'd16:5'd19]: dst_q <= {dst_q[23:0], in_data};
                default:       ;
            endcase
        end
        if (in_end && frame_pass) begin
            src_ip <= src_q;
            dst_ip <= dst_q;
        end
    end

endmodule

// ==== hw/mac_rx.sv ====
`timescale 1ns/1ps

module mac_rx #(
    parameter logic [eth_rx_pkg::MAC_W-1:0] LOCAL_MAC = 48'h02_00_00_00_00_01
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [7:0]                   in_data,
    input  logic                         in_valid,
    input  logic                         in_end,
    input  logic                         in_ok,
    output logic [7:0]                   ip_data,
    output logic                         ip_valid,
    output logic                         ip_end,
    output logic                         ip_ok,
    output logic [eth_rx_pkg::MAC_W-1:0] src_mac,
    output logic [eth_rx_pkg::MAC_W-1:0] dst_mac
);

    eth_rx_pkg::hdr_state_t state;

    logic [3:0]                   hdr_cnt;
    logic [eth_rx_pkg::MAC_W-1:0] dst_q;
    logic [eth_rx_pkg::MAC_W-1:0] src_q;
    logic [15:0]                  type_q;
    logic                         hdr_pass;
    logic                         frame_pass;

    // unicast to us or broadcast, ipv4 only.
    assign hdr_pass = ((dst_q == LOCAL_MAC) || (dst_q == '1)) &&
                      (type_q == eth_rx_pkg::ETHERTYPE_IPV4);
    assign frame_pass = in_ok && (state == eth_rx_pkg::PAYLOAD) && hdr_pass;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= eth_rx_pkg::HEADER;
            hdr_cnt  <= '0;
            ip_valid <= 1'b0;
            ip_end   <= 1'b0;
            ip_ok    <= 1'b0;
        end else begin
            ip_valid <= 1'b0;
            ip_end   <= in_end;
            if (in_end) begin
                ip_ok   <= frame_pass;
                state   <= eth_rx_pkg::HEADER;
                hdr_cnt <= '0;
            end else if (in_valid) begin
                case (state)
                    eth_rx_pkg::HEADER: begin
                        hdr_cnt <= hdr_cnt + 4'd1;
                        if (hdr_cnt == 4'd13) begin
                            state <= eth_rx_pkg::PAYLOAD;
                        end
                    end
                    eth_rx_pkg::PAYLOAD: begin
                        if (hdr_pass) begin
                            ip_valid <= 1'b1;
                        end else begin
                            state <= eth_rx_pkg::SKIP;
                        end
                    end
                    default: state <= eth_rx_pkg::SKIP;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        ip_data <= in_data;
        if (in_valid && (state == eth_rx_pkg::HEADER)) begin
            {dst_q, src_q, type_q} <= {dst_q[eth_rx_pkg::MAC_W-9:0], src_q, type_q, in_data};
        end
        if (in_end && frame_pass) begin
            dst_mac <= dst_q;
            src_mac <= src_q;
        end
    end

endmodule

// ==== hw/payload_fifo.sv ====
`timescale 1ns/1ps

module payload_fifo #(
    parameter int FIFO_DEPTH = 256
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] wr_data,
    input  logic       wr_en,
    input  logic       wr_last,
    input  logic       commit,
    input  logic       discard,
    input  logic       out_ready,
    output logic       overflow,
    output logic [7:0] out_data,
    output logic       out_valid,
    output logic       out_last
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [8:0]  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] commit_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_wr;

    // full counts uncommitted bytes too.
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_wr = wr_en && !full && !overflow;

    // only committed bytes are visible to the reader.
    assign out_valid            = (commit_ptr != rd_ptr);
    assign {out_last, out_data} = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            overflow   <= 1'b0;
        end else begin
            if (discard) begin
                wr_ptr   <= commit_ptr;
                overflow <= 1'b0;
            end else begin
                if (do_wr) begin
                    wr_ptr <= wr_ptr + (AW + 1)'(1);
                end
                if (commit) begin
                    commit_ptr <= wr_ptr;
                    overflow   <= 1'b0;
                end else if (wr_en && full) begin
                    overflow <= 1'b1;
                end
            end
            if (out_valid && out_ready) begin
                rd_ptr <= rd_ptr + (AW + 1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= {wr_last, wr_data};
        end
    end

endmodule

// ==== hw/udp_rx.sv ====
`timescale 1ns/1ps

module udp_rx (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [7:0]                    in_data,
    input  logic                          in_valid,
    input  logic                          in_end,
    input  logic                          in_ok,
    input  logic                          overflow,
    output logic [7:0]                    wr_data,
    output logic                          wr_en,
    output logic                          wr_last,
    output logic                          commit,
    output logic                          discard,
    output logic [eth_rx_pkg::PORT_W-1:0] src_port,
    output logic [eth_rx_pkg::PORT_W-1:0] dst_port,
    output logic [eth_rx_pkg::LEN_W-1:0]  payload_len,
    output logic                          hdr_valid
);

    eth_rx_pkg::hdr_state_t state;

    logic [2:0]                    hdr_cnt;
    logic [eth_rx_pkg::PORT_W-1:0] src_q;
    logic [eth_rx_pkg::PORT_W-1:0] dst_q;
    logic [eth_rx_pkg::LEN_W-1:0]  len_q;
    logic [eth_rx_pkg::LEN_W-1:0]  left;
    logic                          accept;

    // every payload byte arrived, upstream is happy and the fifo kept up.
    assign accept = in_ok && !overflow && (state == eth_rx_pkg::PAYLOAD) && (left == 16'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= eth_rx_pkg::HEADER;
            hdr_cnt   <= '0;
            left      <= '0;
            wr_en     <= 1'b0;
            commit    <= 1'b0;
            discard   <= 1'b0;
            hdr_valid <= 1'b0;
        end else begin
            wr_en     <= 1'b0;
            commit    <= in_end && accept;
            discard   <= in_end && !accept;
            hdr_valid <= in_end && accept;
            if (in_end) begin
                state   <= eth_rx_pkg::HEADER;
                hdr_cnt <= '0;
            end else if (in_valid) begin
                case (state)
                    eth_rx_pkg::HEADER: begin
                        hdr_cnt <= hdr_cnt + 3'd1;
                        if (hdr_cnt == 3'd7) begin
                            state <= (len_q < 16'd8) ? eth_rx_pkg::SKIP : eth_rx_pkg::PAYLOAD;
                            left  <= len_q - 16'd8;
                        end
                    end
                    eth_rx_pkg::PAYLOAD: begin
                        if (left != 16'd0) begin
                            wr_en <= 1'b1;
                            left  <= left - 16'd1;
                        end
                    end
                    default: state <= eth_rx_pkg::SKIP;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= in_data;
        wr_last <= (left == 16'd1);
        if (in_valid && (state == eth_rx_pkg::HEADER)) begin
            case (hdr_cnt)
                3'd0, 3'd1: src_q <= {src_q[7:0], in_data};
                3'd2, 3'd3: dst_q <= {dst_q[7:0], in_data};
                3'd4, 3'd5: len_q <= {len_q[7:0], in_data};
                default:    ;
            endcase
        end
        // fields stay put until the next accepted frame.
        if (in_end && accept) begin
            src_port    <= src_q;
            dst_port    <= dst_q;
            payload_len <= len_q - 16'd8;
        end
    end

endmodule

// ==== include/eth_frame_model.svh ====
`ifndef ETH_FRAME_MODEL_SVH
`define ETH_FRAME_MODEL_SVH

typedef struct {
    logic [eth_rx_pkg::MAC_W-1:0]  dst_mac;
    logic [eth_rx_pkg::MAC_W-1:0]  src_mac;
    logic [15:0]                   eth_type;
    logic [7:0]                    proto;
    logic [eth_rx_pkg::IP_W-1:0]   src_ip;
    logic [eth_rx_pkg::IP_W-1:0]   dst_ip;
    logic [15:0]                   frag;
    logic [eth_rx_pkg::PORT_W-1:0] src_port;
    logic [eth_rx_pkg::PORT_W-1:0] dst_port;
    bit                            bad_fcs;
    bit                            no_sfd;
    bit                            no_pad;
} frame_cfg_t;

// returns the fcs value, already complemented.
function automatic logic [31:0] model_crc32(input byte unsigned data[$]);
    logic [31:0] crc;
    crc = '1;
    foreach (data[i]) begin
        crc ^= {24'd0, data[i]};
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
        end
    end
    return ~crc;
endfunction

// big-endian push of the low nbytes.
function automatic void push_be(ref byte unsigned q[$], input logic [63:0] value,
                                input int nbytes);
    for (int i = nbytes - 1; i >= 0; i--) begin
        q.push_back(value[8*i +: 8]);
    end
endfunction

function automatic void build_frame(input frame_cfg_t cfg, input byte unsigned payload[$],
                                    output byte unsigned frame[$]);
    byte unsigned body[$];
    logic [31:0]  fcs;
    push_be(body, 64'(cfg.dst_mac), 6);
    push_be(body, 64'(cfg.src_mac), 6);
    push_be(body, 64'(cfg.eth_type), 2);
    push_be(body, 64'h4500, 2);
    push_be(body, 64'(28 + payload.size()), 2);
    push_be(body, 64'h0000, 2);
    push_be(body, 64'(cfg.frag), 2);
    // ttl, protocol and a checksum the receiver ignores.
    push_be(body, 64'({8'd64, cfg.proto, 16'd0}), 4);
    push_be(body, 64'(cfg.src_ip), 4);
    push_be(body, 64'(cfg.dst_ip), 4);
    push_be(body, 64'(cfg.src_port), 2);
    push_be(body, 64'(cfg.dst_port), 2);
    push_be(body, 64'(8 + payload.size()), 2);
    push_be(body, 64'h0000, 2);
    body = {body, payload};
    while (!cfg.no_pad && body.size() < 60) begin
        body.push_back(8'h00);
    end
    fcs = model_crc32(body);
    if (cfg.bad_fcs) begin
        fcs ^= 32'h0000_0100;
    end
    for (int i = 0; i < 4; i++) begin
        body.push_back(fcs[8*i +: 8]);
    end
    frame = {};
    repeat (7) begin
        frame.push_back(8'h55);
    end
    frame.push_back(cfg.no_sfd ? 8'h55 : 8'hD5);
    frame = {frame, body};
endfunction

function automatic bit frame_accepted(input frame_cfg_t cfg, input int payload_len,
                                      input int free_space,
                                      input logic [eth_rx_pkg::MAC_W-1:0] local_mac,
                                      input logic [eth_rx_pkg::IP_W-1:0] local_ip);
    int wire_bytes;
    wire_bytes = 42 + payload_len;
    if (!cfg.no_pad && wire_bytes < 60) begin
        wire_bytes = 60;
    end
    wire_bytes += 4;
    return !cfg.bad_fcs && !cfg.no_sfd
        && (wire_bytes >= int'(eth_rx_pkg::MIN_FRAME_BYTES))
        && ((cfg.dst_mac == local_mac) || (cfg.dst_mac == '1))
        && (cfg.eth_type == eth_rx_pkg::ETHERTYPE_IPV4)
        && (cfg.proto == eth_rx_pkg::IP_PROTO_UDP)
        && (cfg.dst_ip == local_ip)
        && (cfg.frag[13:0] == 14'd0)
        && (payload_len <= free_space);
endfunction

`endif

// ==== testbench/tb_eth_rx_top.sv ====
`timescale 1ns/1ps

module tb_eth_rx_top;

    localparam logic [eth_rx_pkg::MAC_W-1:0] LOCAL_MAC  = 48'h02_00_00_00_00_01;
    localparam logic [eth_rx_pkg::IP_W-1:0]  LOCAL_IP   = 32'h0A_00_00_02;
    localparam int                           FIFO_DEPTH = 256;

    localparam int READY_RANDOM = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_HIGH   = 2;

    `include "eth_frame_model.svh"

    logic                          clk;
    logic                          arst_n;
    logic [7:0]                    rxd;
    logic                          rxdv;
    logic                          out_ready;
    logic [7:0]                    out_data;
    logic                          out_valid;
    logic                          out_last;
    logic                          hdr_valid;
    logic [eth_rx_pkg::MAC_W-1:0]  src_mac;
    logic [eth_rx_pkg::MAC_W-1:0]  dst_mac;
    logic [eth_rx_pkg::IP_W-1:0]   src_ip;
    logic [eth_rx_pkg::IP_W-1:0]   dst_ip;
    logic [eth_rx_pkg::PORT_W-1:0] src_port;
    logic [eth_rx_pkg::PORT_W-1:0] dst_port;
    logic [eth_rx_pkg::LEN_W-1:0]  payload_len;

    // expected results of accepted frames, oldest first.
    frame_cfg_t exp_cfg_q[$];
    int         exp_len_q[$];
    logic [8:0] exp_byte_q[$];

    int         ready_mode = READY_RANDOM;
    int         bytes_sent = 0;
    frame_cfg_t mon_cfg;
    int         mon_len;
    logic [8:0] mon_byte;
    logic [8:0] stall_word;
    bit         stalled = 1'b0;

    eth_rx_top #(
        .LOCAL_MAC(LOCAL_MAC),
        .LOCAL_IP(LOCAL_IP),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_eth_rx_top (
        .clk(clk), .arst_n(arst_n), .rxd(rxd), .rxdv(rxdv), .out_ready(out_ready),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .hdr_valid(hdr_valid), .src_mac(src_mac), .dst_mac(dst_mac),
        .src_ip(src_ip), .dst_ip(dst_ip), .src_port(src_port), .dst_port(dst_port),
        .payload_len(payload_len)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        assert (actual === expected) else begin
            stop_with_failure($sformatf("[ERROR] %0.1f ns %s expected %0h actual %0h",
                                        $realtime, name, expected, actual));
        end
    endtask

    function automatic frame_cfg_t good_cfg();
        frame_cfg_t cfg;
        cfg.dst_mac  = LOCAL_MAC;
        cfg.src_mac  = {16'h0211, 32'($urandom)};
        cfg.eth_type = eth_rx_pkg::ETHERTYPE_IPV4;
        cfg.proto    = eth_rx_pkg::IP_PROTO_UDP;
        cfg.src_ip   = {24'h0A_00_00, 8'($urandom)};
        cfg.dst_ip   = LOCAL_IP;
        cfg.frag     = 16'h0000;
        cfg.src_port = 16'($urandom);
        cfg.dst_port = 16'($urandom);
        cfg.bad_fcs  = 1'b0;
        cfg.no_sfd   = 1'b0;
        cfg.no_pad   = 1'b0;
        return cfg;
    endfunction

    // with the reader running, only an upper bound of the used space is known.
    task automatic wait_for_space(input int len);
        while (FIFO_DEPTH - exp_byte_q.size() < len) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    task automatic send_frame(input frame_cfg_t cfg, input int len);
        byte unsigned payload[$];
        byte unsigned frame[$];
        bit           accept;
        if (ready_mode != READY_LOW) begin
            wait_for_space(len);
        end
        repeat (len) begin
            payload.push_back(8'($urandom));
        end
        build_frame(cfg, payload, frame);
        accept = frame_accepted(cfg, len, FIFO_DEPTH - exp_byte_q.size(), LOCAL_MAC, LOCAL_IP);
        if (accept) begin
            exp_cfg_q.push_back(cfg);
            exp_len_q.push_back(len);
            foreach (payload[i]) begin
                exp_byte_q.push_back({(i == len - 1), payload[i]});
            end
        end
        bytes_sent += frame.size();
        foreach (frame[i]) begin
            rxd  = frame[i];
            rxdv = 1'b1;
            @(posedge clk);
            #0.5;
        end
        rxd  = 8'h00;
        rxdv = 1'b0;
        // inter-frame gap.
        repeat (12) begin
            @(posedge clk);
            #0.5;
        end
    endtask

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #0.5;
            case (ready_mode)
                READY_LOW:  out_ready = 1'b0;
                READY_HIGH: out_ready = 1'b1;
                default:    out_ready = 1'($urandom_range(0, 1));
            endcase
        end
    end

    // samples on the falling edge, halfway between drive and capture.
    initial begin
        forever begin
            @(negedge clk);
            if (arst_n) begin
                if (hdr_valid) begin
                    assert (exp_cfg_q.size() != 0) else begin
                        stop_with_failure("hdr_valid pulsed while no frame was expected");
                    end
                    mon_cfg = exp_cfg_q.pop_front();
                    mon_len = exp_len_q.pop_front();
                    compare_field("dst_mac", 64'(mon_cfg.dst_mac), 64'(dst_mac));
                    compare_field("src_mac", 64'(mon_cfg.src_mac), 64'(src_mac));
                    compare_field("src_ip", 64'(mon_cfg.src_ip), 64'(src_ip));
                    compare_field("dst_ip", 64'(mon_cfg.dst_ip), 64'(dst_ip));
                    compare_field("src_port", 64'(mon_cfg.src_port), 64'(src_port));
                    compare_field("dst_port", 64'(mon_cfg.dst_port), 64'(dst_port));
                    compare_field("payload_len", 64'(mon_len), 64'(payload_len));
                end
                if (stalled) begin
                    compare_field("out_valid", 64'(1'b1), 64'(out_valid));
                    compare_field("out_data", 64'(stall_word[7:0]), 64'(out_data));
                    compare_field("out_last", 64'(stall_word[8]), 64'(out_last));
                end
                if (out_valid) begin
                    assert (exp_byte_q.size() != 0) else begin
                        stop_with_failure("payload byte came out while none was expected");
                    end
                    if (out_ready) begin
                        mon_byte = exp_byte_q.pop_front();
                        compare_field("out_data", 64'(mon_byte[7:0]), 64'(out_data));
                        compare_field("out_last", 64'(mon_byte[8]), 64'(out_last));
                    end
                end
                stalled    = out_valid && !out_ready;
                stall_word = {out_last, out_data};
            end
        end
    end

    // 4 ns per byte with a factor of three margin.
    initial begin
        forever begin
            @(posedge clk);
            if ($realtime > 10000.0 + 12.0 * bytes_sent) begin
                stop_with_failure("timeout, the DUT stopped making progress");
            end
        end
    end

    initial begin
        frame_cfg_t cfg;
        int         drain_cycles;
        arst_n = 1'b0;
        rxd    = 8'h00;
        rxdv   = 1'b0;
        void'($urandom(32'hbc8ed828));
        repeat (10) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        repeat (4) @(posedge clk);
        #0.5;

        repeat (6) begin
            send_frame(good_cfg(), $urandom_range(1, 200));
        end

        cfg = good_cfg();
        cfg.dst_mac = '1;
        send_frame(cfg, 40);
        cfg = good_cfg();
        cfg.dst_mac = 48'h02_00_00_00_00_07;
        send_frame(cfg, 40);
        send_frame(good_cfg(), 33);
        cfg = good_cfg();
        cfg.eth_type = 16'h0806;
        send_frame(cfg, 40);
        send_frame(good_cfg(), 34);
        cfg = good_cfg();
        cfg.proto = 8'd6;
        send_frame(cfg, 40);
        send_frame(good_cfg(), 35);
        cfg = good_cfg();
        cfg.dst_ip = 32'h0A_00_00_09;
        send_frame(cfg, 40);
        send_frame(good_cfg(), 36);
        cfg = good_cfg();
        cfg.frag = 16'h2000;
        send_frame(cfg, 40);
        cfg = good_cfg();
        cfg.frag = 16'h0005;
        send_frame(cfg, 40);
        send_frame(good_cfg(), 37);
        // don't fragment alone is fine.
        cfg = good_cfg();
        cfg.frag = 16'h4000;
        send_frame(cfg, 38);

        cfg = good_cfg();
        cfg.bad_fcs = 1'b1;
        send_frame(cfg, 30);
        send_frame(good_cfg(), 31);
        cfg = good_cfg();
        cfg.no_pad = 1'b1;
        send_frame(cfg, 4);
        send_frame(good_cfg(), 32);
        cfg = good_cfg();
        cfg.no_sfd = 1'b1;
        send_frame(cfg, 30);
        send_frame(good_cfg(), 29);

        send_frame(good_cfg(), 1);
        send_frame(good_cfg(), 5);
        send_frame(good_cfg(), 17);

        // reader stopped, so the free space is exact and the middle frame drops.
        wait_for_space(FIFO_DEPTH);
        ready_mode = READY_LOW;
        send_frame(good_cfg(), 150);
        send_frame(good_cfg(), 150);
        send_frame(good_cfg(), 100);
        repeat (50) @(posedge clk);
        #0.5;
        ready_mode = READY_RANDOM;
        wait_for_space(FIFO_DEPTH);
        send_frame(good_cfg(), 200);

        send_frame(good_cfg(), 0);
        send_frame(good_cfg(), 0);
        send_frame(good_cfg(), 0);
        send_frame(good_cfg(), 3);

        ready_mode   = READY_HIGH;
        drain_cycles = 0;
        while ((exp_cfg_q.size() != 0 || exp_byte_q.size() != 0) && drain_cycles < 4000) begin
            @(posedge clk);
            drain_cycles++;
        end
        repeat (20) @(posedge clk);
        if (exp_cfg_q.size() != 0 || exp_byte_q.size() != 0) begin
            stop_with_failure($sformatf("missing frames: %0d headers and %0d bytes never came out",
                                        exp_cfg_q.size(), exp_byte_q.size()));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
